//--- forthRegs.f
rtl/regSeqPkg.sv
rtl/regCtrlIf.sv
rtl/cyclePhaseGen.sv
rtl/opxDecoder.sv
rtl/registerSequencer.sv
rtl/registerFile.sv
rtl/regSubsystemTop.sv
dv/regSubsystemTb.sv

//--- Bender.yml
package:
  name: forthRegs

sources:
  - files:
      - rtl/regSeqPkg.sv
      - rtl/regCtrlIf.sv
      - rtl/cyclePhaseGen.sv
      - rtl/opxDecoder.sv
      - rtl/registerSequencer.sv
      - rtl/registerFile.sv
      - rtl/regSubsystemTop.sv
  - target: simulation
    files:
      - dv/regSubsystemTb.sv

//--- dv/regSubsystemTb.sv
module regSubsystemTb;

	timeunit 1ns;
	timeprecision 100ps;

	logic                              CLK;
	logic                              RESET;
	logic [regSeqPkg::INSTR_W-1:0]     instr;
	logic [regSeqPkg::DATA_W-1:0]      loadData;
	logic                              fetch;
	logic [regSeqPkg::DATA_W-1:0]      regAData;
	logic [regSeqPkg::DATA_W-1:0]      regBData;
	logic                              regaWen;
	logic                              regbWen;

	string       tName [$];                           // Test table, one slot per entry.
	logic [15:0] tInstr [$];
	logic [15:0] tData [$];
	logic [15:0] tExpA [$];                           // Expected reads in COMMIT.
	logic [15:0] tExpB [$];
	logic        tExpAWen [$];
	logic        tExpBWen [$];

	logic [15:0] modelRegs [8];                       // Reference register contents.
	logic [31:0] lfsrState;                           // Galois LFSR state.
	int          errCount;
	int          passCount;
	int          failCount;
	bit          tableReady;

	regSubsystemTop regSubsystemTop_i (
		.CLK(CLK), .RESET(RESET), .instr(instr), .loadData(loadData), .fetch(fetch),
		.regAData(regAData), .regBData(regBData), .regaWen(regaWen), .regbWen(regbWen)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;                          // 8 ns period.
	end

	function automatic logic lfsrBit();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit) begin
			lfsrState = lfsrState ^ 32'hB4BCD35C;           // Feedback taps.
		end
		return outBit;
	endfunction

	function automatic logic [15:0] lfsrBits(input int count);
		logic [15:0] val;
		val = '0;
		for (int k = 0; k < count; k++) begin
			val = {val[14:0], lfsrBit()};                  // One step per bit.
		end
		return val;
	endfunction

	function automatic logic [15:0] encodeInstr(input logic [3:0] opc, input logic isByte,
		input logic [2:0] ra, input logic [2:0] rb);
		return {opc, isByte, ra, rb, 5'b00000};
	endfunction

	function automatic logic [15:0] encodeImm(input logic [2:0] ra, input logic [7:0] imm);
		return {regSeqPkg::seqLdaImm, 1'b0, ra, imm};
	endfunction

	// Derive the expected COMMIT view, then apply the write to the model.
	task automatic addTest(input string name, input logic [15:0] ins, input logic [15:0] data);
		logic [3:0]  opc;
		logic        isByte;
		logic [2:0]  ra;
		logic [2:0]  rb;
		logic        aEn;
		logic        bEn;
		logic        aWen;
		logic        bWen;
		logic [15:0] oldA;
		logic [15:0] oldB;
		logic [15:0] mask;
		opc    = ins[15:12];
		isByte = ins[11];
		ra     = ins[10:8];
		rb     = ins[7:5];
		oldA   = modelRegs[ra];
		oldB   = modelRegs[rb];
		aEn    = (opc >= 4'd1) && (opc <= 4'd5);        // Undefined codes act as seqNone.
		bEn    = aEn && (opc != regSeqPkg::seqLdaImm);
		aWen   = (opc == regSeqPkg::seqLdaRdb) || (opc == regSeqPkg::seqLdaUpb) ||
			(opc == regSeqPkg::seqLdaImm);
		bWen   = (opc == regSeqPkg::seqLdaUpb) || (opc == regSeqPkg::seqRdaUpb);
		tName.push_back(name);
		tInstr.push_back(ins);
		tData.push_back(data);
		tExpA.push_back(aEn ? oldA : 16'h0000);
		tExpB.push_back(bEn ? oldB : 16'h0000);
		tExpAWen.push_back(aWen);
		tExpBWen.push_back(bWen);
		if (!isByte) begin
			mask = 16'hFFFF;
		end else begin
			mask = oldB[0] ? 16'hFF00 : 16'h00FF;          // Lane from A0 of rB.
		end
		if (bWen && !(aWen && (ra == rb))) begin
			modelRegs[rb] = oldB + (isByte ? 16'd1 : 16'd2);  // Wraps at 16 bits.
		end
		if (opc == regSeqPkg::seqLdaImm) begin
			modelRegs[ra] = {8'h00, ins[7:0]};
		end else if (aWen) begin
			modelRegs[ra] = (oldA & ~mask) | (data & mask);
		end
	endtask

	task automatic buildTable();
		logic [15:0] rInstr;
		for (int r = 0; r < 8; r++) begin
			modelRegs[r] = '0;
		end
		addTest("none-op", encodeInstr(regSeqPkg::seqNone, 1'b0, 3'd1, 3'd2), 16'h1234);
		addTest("undef-op", encodeInstr(4'hF, 1'b1, 3'd3, 3'd4), 16'hBEEF);
		addTest("read-zero", encodeInstr(regSeqPkg::seqRdaRdb, 1'b0, 3'd3, 3'd6), 16'h0000);
		addTest("ldimm-r2", encodeImm(3'd2, 8'hA5), 16'hFFFF);
		addTest("read-imm", encodeInstr(regSeqPkg::seqRdaRdb, 1'b0, 3'd2, 3'd2), 16'h0000);
		addTest("ldword-r1", encodeInstr(regSeqPkg::seqLdaRdb, 1'b0, 3'd1, 3'd0), lfsrBits(16));
		addTest("read-word", encodeInstr(regSeqPkg::seqRdaRdb, 1'b0, 3'd1, 3'd1), 16'h0000);
		addTest("ldbyte-even", encodeInstr(regSeqPkg::seqLdaRdb, 1'b1, 3'd4, 3'd0), lfsrBits(16));
		addTest("ldimm-odd", encodeImm(3'd5, 8'h33), 16'h0000);
		addTest("ldbyte-odd", encodeInstr(regSeqPkg::seqLdaRdb, 1'b1, 3'd4, 3'd5), lfsrBits(16));
		addTest("read-bytes", encodeInstr(regSeqPkg::seqRdaRdb, 1'b0, 3'd4, 3'd5), 16'h0000);
		addTest("bump-word", encodeInstr(regSeqPkg::seqRdaUpb, 1'b0, 3'd1, 3'd5), 16'h0000);
		addTest("bump-byte", encodeInstr(regSeqPkg::seqRdaUpb, 1'b1, 3'd1, 3'd5), 16'h0000);
		addTest("ldupb-word", encodeInstr(regSeqPkg::seqLdaUpb, 1'b0, 3'd6, 3'd7), lfsrBits(16));
		addTest("ld-ffff", encodeInstr(regSeqPkg::seqLdaRdb, 1'b0, 3'd3, 3'd5), 16'hFFFF);
		addTest("bump-wrap", encodeInstr(regSeqPkg::seqRdaUpb, 1'b0, 3'd3, 3'd3), 16'h0000);
		addTest("same-reg", encodeInstr(regSeqPkg::seqLdaUpb, 1'b0, 3'd2, 3'd2), lfsrBits(16));
		addTest("read-back", encodeInstr(regSeqPkg::seqRdaRdb, 1'b0, 3'd3, 3'd2), 16'h0000);
		for (int n = 0; n < 24; n++) begin
			rInstr = lfsrBits(16);
			rInstr[15] = 1'b0;                             // Opcodes 0 to 7, 6 and 7 undefined.
			addTest($sformatf("random-%0d", n), rInstr, lfsrBits(16));
		end
		addTest("read-final", encodeInstr(regSeqPkg::seqRdaRdb, 1'b0, 3'd6, 3'd7), 16'h0000);
	endtask

	task automatic compareValue(input string name, input string what,
		input logic [15:0] exp, input logic [15:0] act);
		assert (act === exp) else begin
			$display("CHECK FAILED %s %s expected %h actual %h", name, what, exp, act);
			errCount++;
		end
	endtask

	task automatic waitFetch();
		do begin
			@(posedge CLK);
			#1;                                            // Drive point inside the cycle.
		end while (!fetch);
	endtask

	initial begin
		wait (tableReady);
		#((tName.size() + 20) * 4 * 8);                  // Whole table plus margin.
		$display("Watchdog expired before the test table finished.");
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		int errBefore;
		RESET      = 1'b1;
		instr      = '0;
		loadData   = '0;
		errCount   = 0;
		passCount  = 0;
		failCount  = 0;
		tableReady = 1'b0;
		lfsrState  = 32'd74627;
		buildTable();
		tableReady = 1'b1;
		repeat (8) @(posedge CLK);
		#1 RESET = 1'b0;
		for (int i = 0; i < tName.size(); i++) begin
			waitFetch();
			instr     = tInstr[i];
			loadData  = tData[i];                          // Held through COMMIT.
			errBefore = errCount;
			@(posedge CLK);                                // FETCH ends.
			@(posedge CLK);                                // DECODE ends, instruction taken.
			@(negedge CLK);
			assert (!regaWen && !regbWen) else begin
				$display("Write enable was high during EXECUTE in test %s.", tName[i]);
				errCount++;
			end
			@(posedge CLK);
			@(negedge CLK);                                // Middle of COMMIT.
			compareValue(tName[i], "regAData", tExpA[i], regAData);
			compareValue(tName[i], "regBData", tExpB[i], regBData);
			compareValue(tName[i], "regaWen", tExpAWen[i], regaWen);
			compareValue(tName[i], "regbWen", tExpBWen[i], regbWen);
			if (errCount == errBefore) begin
				passCount++;
				$display("test %-12s ok", tName[i]);
			end else begin
				failCount++;
				$display("test %-12s mismatch", tName[i]);
			end
		end
		$display("Tests %0d, passed %0d, failed %0d", tName.size(), passCount, failCount);
		if (failCount == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- rtl/regSubsystemTop.sv
module regSubsystemTop (
	input  logic                           CLK,
	input  logic                           RESET,
	input  logic [regSeqPkg::INSTR_W-1:0]  instr,
	input  logic [regSeqPkg::DATA_W-1:0]   loadData,
	output logic                           fetch,
	output logic [regSeqPkg::DATA_W-1:0]   regAData,
	output logic [regSeqPkg::DATA_W-1:0]   regBData,
	output logic                           regaWen,
	output logic                           regbWen
);

	logic                              decode;       // Phase strobes.
	logic                              execute;
	logic                              commit;
	regSeqPkg::regSeqE                 regSeq;
	logic                              byteOp;
	logic [regSeqPkg::REG_ADDR_W-1:0]  addrA;
	logic [regSeqPkg::REG_ADDR_W-1:0]  addrB;
	logic [regSeqPkg::IMM_W-1:0]       imm;
	logic                              immSel;       // Port A takes the immediate.

	regCtrlIf ctrl ();

	cyclePhaseGen cyclePhaseGen_i (
		.CLK(CLK), .RESET(RESET),
		.fetch(fetch), .decode(decode), .execute(execute), .commit(commit)
	);

	opxDecoder opxDecoder_i (
		.CLK(CLK), .RESET(RESET), .decode(decode), .instr(instr),
		.regSeq(regSeq), .byteOp(byteOp), .addrA(addrA), .addrB(addrB), .imm(imm)
	);

	registerSequencer registerSequencer_i (
		.CLK(CLK), .RESET(RESET),
		.decode(decode), .execute(execute), .commit(commit),
		.regSeq(regSeq), .byteOp(byteOp), .A0(regBData[0]), .ctrl(ctrl.seq)
	);

	assign immSel = (regSeq == regSeqPkg::seqLdaImm);

	registerFile registerFile_i (
		.CLK(CLK), .RESET(RESET), .ctrl(ctrl.rf),
		.addrA(addrA), .addrB(addrB), .loadData(loadData), .imm(imm),
		.immSel(immSel), .byteOp(byteOp), .regAData(regAData), .regBData(regBData)
	);

	always_comb begin
		regaWen = ctrl.regaWen;                        // Write strobes seen from outside.
		regbWen = ctrl.regbWen;
	end

endmodule

//--- rtl/registerFile.sv
module registerFile (
	input  logic                              CLK,
	input  logic                              RESET,
	regCtrlIf.rf                              ctrl,
	input  logic [regSeqPkg::REG_ADDR_W-1:0]  addrA,
	input  logic [regSeqPkg::REG_ADDR_W-1:0]  addrB,
	input  logic [regSeqPkg::DATA_W-1:0]      loadData,
	input  logic [regSeqPkg::IMM_W-1:0]       imm,
	input  logic                              immSel,
	input  logic                              byteOp,
	output logic [regSeqPkg::DATA_W-1:0]      regAData,
	output logic [regSeqPkg::DATA_W-1:0]      regBData
);

	logic [regSeqPkg::DATA_W-1:0] regs [regSeqPkg::REG_COUNT];
	logic [regSeqPkg::DATA_W-1:0] loadWord;          // Value offered to port A.
	logic [regSeqPkg::DATA_W-1:0] laneMask;          // Bits port A may change.
	logic [regSeqPkg::DATA_W-1:0] aNext;
	logic [regSeqPkg::DATA_W-1:0] incStep;           // Post-increment size.
	logic                         loadWins;          // Same register on both ports.

	assign loadWord = immSel ?
		{{(regSeqPkg::DATA_W - regSeqPkg::IMM_W){1'b0}}, imm} : loadData;
	assign laneMask = immSel ? '1 :
		{{regSeqPkg::BYTE_W{ctrl.regaByteEn[1]}}, {regSeqPkg::BYTE_W{ctrl.regaByteEn[0]}}};
	assign aNext    = (regs[addrA] & ~laneMask) | (loadWord & laneMask);
	assign incStep  = byteOp ? regSeqPkg::DATA_W'(1) : regSeqPkg::DATA_W'(2);
	assign loadWins = ctrl.regaWen && (addrA == addrB);

	// Writes land on the edge that ends COMMIT.
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			for (int i = 0; i < regSeqPkg::REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (ctrl.regbWen && !loadWins) begin
				regs[addrB] <= regs[addrB] + incStep;      // Wraps modulo 2**16.
			end
			if (ctrl.regaWen) begin
				regs[addrA] <= aNext;
			end
		end
	end

	assign regAData = ctrl.regaEn ? regs[addrA] : '0;  // Zero outside the window.
	assign regBData = ctrl.regbEn ? regs[addrB] : '0;

	bumpAfterRead: assert property (@(posedge CLK) disable iff (RESET)
		ctrl.regbWen |-> ctrl.regbEn && $past(ctrl.regbEn));

endmodule

//--- rtl/registerSequencer.sv
module registerSequencer (
	input  logic              CLK,
	input  logic              RESET,
	input  logic              decode,
	input  logic              execute,
	input  logic              commit,
	input  regSeqPkg::regSeqE regSeq,
	input  logic              byteOp,
	input  logic              A0,
	regCtrlIf.seq             ctrl
);

	logic       aEnNext;                             // Decoded controls for regSeq.
	logic       bEnNext;
	logic       aWenNext;
	logic       bWenNext;
	logic [1:0] byteEnNext;

	always_comb begin
		aEnNext  = 1'b0;
		bEnNext  = 1'b0;
		aWenNext = 1'b0;
		bWenNext = 1'b0;
		case (regSeq)
			regSeqPkg::seqRdaRdb: begin
				aEnNext = 1'b1;
				bEnNext = 1'b1;
			end
			regSeqPkg::seqLdaRdb: begin
				aEnNext  = 1'b1;
				bEnNext  = 1'b1;
				aWenNext = 1'b1;
			end
			regSeqPkg::seqLdaUpb: begin
				aEnNext  = 1'b1;
				bEnNext  = 1'b1;
				aWenNext = 1'b1;
				bWenNext = 1'b1;
			end
			regSeqPkg::seqRdaUpb: begin
				aEnNext  = 1'b1;
				bEnNext  = 1'b1;
				bWenNext = 1'b1;
			end
			regSeqPkg::seqLdaImm: begin
				aEnNext  = 1'b1;                           // Port B stays idle.
				aWenNext = 1'b1;
			end
			default: ;                                   // seqNone, all low.
		endcase
	end

	// Byte lane follows bit 0 of the port B register value.
	always_comb begin
		if (regSeq == regSeqPkg::seqLdaRdb || regSeq == regSeqPkg::seqLdaUpb) begin
			if (!byteOp) begin
				byteEnNext = regSeqPkg::byteEnBoth;
			end else begin
				byteEnNext = A0 ? regSeqPkg::byteEnHigh : regSeqPkg::byteEnLow;
			end
		end else if (regSeq == regSeqPkg::seqNone) begin
			byteEnNext = regSeqPkg::byteEnNone;
		end else begin
			byteEnNext = regSeqPkg::byteEnBoth;
		end
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			ctrl.regaEn     <= 1'b0;
			ctrl.regbEn     <= 1'b0;
			ctrl.regaWen    <= 1'b0;
			ctrl.regbWen    <= 1'b0;
			ctrl.regaByteEn <= regSeqPkg::byteEnNone;
		end else if (commit) begin                     // Cycle done, drop everything.
			ctrl.regaEn     <= 1'b0;
			ctrl.regbEn     <= 1'b0;
			ctrl.regaWen    <= 1'b0;
			ctrl.regbWen    <= 1'b0;
			ctrl.regaByteEn <= regSeqPkg::byteEnNone;
		end else if (execute) begin                    // Write window opens.
			ctrl.regaWen    <= aWenNext;
			ctrl.regbWen    <= bWenNext;
			ctrl.regaByteEn <= byteEnNext;               // Refresh now that A0 is read back.
		end else if (decode) begin                     // Read window opens.
			ctrl.regaEn     <= aEnNext;
			ctrl.regbEn     <= bEnNext;
			ctrl.regaByteEn <= byteEnNext;
		end
	end

	wenNeedsEn: assert property (@(posedge CLK) disable iff (RESET)
		(ctrl.regaWen |-> ctrl.regaEn) and (ctrl.regbWen |-> ctrl.regbEn));

	wenOnlyInCommit: assert property (@(posedge CLK) disable iff (RESET)
		!commit |-> !ctrl.regaWen && !ctrl.regbWen);

endmodule

//--- rtl/opxDecoder.sv
module opxDecoder (
	input  logic                                CLK,
	input  logic                                RESET,
	input  logic                                decode,
	input  logic [regSeqPkg::INSTR_W-1:0]       instr,
	output regSeqPkg::regSeqE                   regSeq,
	output logic                                byteOp,
	output logic [regSeqPkg::REG_ADDR_W-1:0]    addrA,
	output logic [regSeqPkg::REG_ADDR_W-1:0]    addrB,
	output logic [regSeqPkg::IMM_W-1:0]         imm
);

	regSeqPkg::regSeqE                     seqNow;   // Decode of the live instruction.
	regSeqPkg::regSeqE                     seqHeld;  // Captured at the end of DECODE.
	logic                                  byteHeld;
	logic [regSeqPkg::REG_ADDR_W-1:0]      addrAHeld;
	logic [regSeqPkg::REG_ADDR_W-1:0]      addrBHeld;
	logic [regSeqPkg::IMM_W-1:0]           immHeld;

	function automatic regSeqPkg::regSeqE mapOpcode(
		input logic [regSeqPkg::OPC_MSB-regSeqPkg::OPC_LSB:0] opc
	);
		regSeqPkg::regSeqE seq;
		case (opc)
			4'd1:    seq = regSeqPkg::seqRdaRdb;
			4'd2:    seq = regSeqPkg::seqLdaRdb;
			4'd3:    seq = regSeqPkg::seqLdaUpb;
			4'd4:    seq = regSeqPkg::seqRdaUpb;
			4'd5:    seq = regSeqPkg::seqLdaImm;
			default: seq = regSeqPkg::seqNone;     // Undefined codes do nothing.
		endcase
		return seq;
	endfunction

	assign seqNow = mapOpcode(instr[regSeqPkg::OPC_MSB:regSeqPkg::OPC_LSB]);

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			seqHeld   <= regSeqPkg::seqNone;
			byteHeld  <= 1'b0;
			addrAHeld <= '0;
			addrBHeld <= '0;
			immHeld   <= '0;
		end else if (decode) begin                     // Edge that ends DECODE.
			seqHeld   <= seqNow;
			byteHeld  <= instr[regSeqPkg::BYTE_BIT];
			addrAHeld <= instr[regSeqPkg::RA_MSB:regSeqPkg::RA_LSB];
			addrBHeld <= instr[regSeqPkg::RB_MSB:regSeqPkg::RB_LSB];
			immHeld   <= instr[regSeqPkg::IMM_MSB:regSeqPkg::IMM_LSB];
		end
	end

	// During DECODE the live decode shows through, so the sequencer can
	// start its enables on the same edge that captures the fields.
	assign regSeq = decode ? seqNow : seqHeld;
	assign byteOp = decode ? instr[regSeqPkg::BYTE_BIT] : byteHeld;
	assign addrA  = decode ? instr[regSeqPkg::RA_MSB:regSeqPkg::RA_LSB] : addrAHeld;
	assign addrB  = decode ? instr[regSeqPkg::RB_MSB:regSeqPkg::RB_LSB] : addrBHeld;
	assign imm    = decode ? instr[regSeqPkg::IMM_MSB:regSeqPkg::IMM_LSB] : immHeld;

endmodule

//--- rtl/cyclePhaseGen.sv
module cyclePhaseGen (
	input  logic CLK,
	input  logic RESET,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit
);

	regSeqPkg::phaseE phase;                         // Current phase.
	regSeqPkg::phaseE phaseNext;

	always_comb begin
		case (phase)
			regSeqPkg::phFetch:   phaseNext = regSeqPkg::phDecode;
			regSeqPkg::phDecode:  phaseNext = regSeqPkg::phExecute;
			regSeqPkg::phExecute: phaseNext = regSeqPkg::phCommit;
			default:              phaseNext = regSeqPkg::phFetch;  // Wrap after COMMIT.
		endcase
	end

	// Strobes decode the next phase so they line up with phase itself.
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			phase   <= regSeqPkg::phFetch;
			fetch   <= 1'b1;                             // FETCH right out of reset.
			decode  <= 1'b0;
			execute <= 1'b0;
			commit  <= 1'b0;
		end else begin
			phase   <= phaseNext;
			fetch   <= (phaseNext == regSeqPkg::phFetch);
			decode  <= (phaseNext == regSeqPkg::phDecode);
			execute <= (phaseNext == regSeqPkg::phExecute);
			commit  <= (phaseNext == regSeqPkg::phCommit);
		end
	end

	strobeOneHot: assert property (@(posedge CLK) disable iff (RESET)
		$onehot({fetch, decode, execute, commit}));

endmodule

//--- rtl/regCtrlIf.sv
interface regCtrlIf;

	logic [1:0] regaByteEn;                          // Lanes written on port A.
	logic       regaEn;                              // Port A read enable.
	logic       regaWen;                             // Port A load in COMMIT.
	logic       regbEn;                              // Port B read enable.
	logic       regbWen;                             // Port B bump in COMMIT.

	modport seq (
		output regaByteEn,
		output regaEn,
		output regaWen,
		output regbEn,
		output regbWen
	);

	modport rf (
		input regaByteEn,
		input regaEn,
		input regaWen,
		input regbEn,
		input regbWen
	);

endinterface

//--- rtl/regSeqPkg.sv
package regSeqPkg;

	localparam int DATA_W     = 16;                  // Register width.
	localparam int REG_ADDR_W = 3;                   // Register address width.
	localparam int REG_COUNT  = 8;                   // Registers in the file.
	localparam int INSTR_W    = 16;                  // Instruction width.
	localparam int BYTE_W     = 8;                   // One byte lane.
	localparam int IMM_W      = 8;                   // Immediate field width.

	localparam int OPC_MSB    = 15;                  // Opcode field.
	localparam int OPC_LSB    = 12;
	localparam int BYTE_BIT   = 11;                  // Set for a byte operation.
	localparam int RA_MSB     = 10;                  // Port A register.
	localparam int RA_LSB     = 8;
	localparam int RB_MSB     = 7;                   // Port B register.
	localparam int RB_LSB     = 5;
	localparam int IMM_MSB    = 7;                   // Overlaps rB, seqLdaImm only.
	localparam int IMM_LSB    = 0;

	// Byte lane enables, bit 1 selects the high lane.
	localparam logic [1:0] byteEnNone = 2'b00;
	localparam logic [1:0] byteEnLow  = 2'b01;
	localparam logic [1:0] byteEnHigh = 2'b10;
	localparam logic [1:0] byteEnBoth = 2'b11;

	typedef enum logic [3:0] {
		seqNone   = 4'd0,                            // No register cycle.
		seqRdaRdb = 4'd1,                            // Read A, read B.
		seqLdaRdb = 4'd2,                            // Load A, read B.
		seqLdaUpb = 4'd3,                            // Load A, bump B.
		seqRdaUpb = 4'd4,                            // Read A, bump B.
		seqLdaImm = 4'd5                             // Load A from immediate.
	} regSeqE;

	typedef enum logic [1:0] {
		phFetch   = 2'd0,
		phDecode  = 2'd1,
		phExecute = 2'd2,
		phCommit  = 2'd3
	} phaseE;

endpackage
